// File: include/maze_defines.svh
// Global constants of the maze view generator
// Screen size, wall map and perspective table, shared by the RTL and the testbench
`ifndef MAZE_DEFINES_SVH
`define MAZE_DEFINES_SVH

`define SCREEN_W      400
`define SCREEN_H      400
`define VIEW_DISPLACE 20        // Added to every emitted coordinate

// Wall map, one bit per column, column 0 in the leftmost bit
`define MAP_COLS 3
`define MAP_ROWS 7
`define MAP_ROW0 3'b111
`define MAP_ROW1 3'b001
`define MAP_ROW2 3'b101
`define MAP_ROW3 3'b001
`define MAP_ROW4 3'b101
`define MAP_ROW5 3'b001
`define MAP_ROW6 3'b101

// Perspective distance of each depth step from the screen edge
`define MAX_DEPTH 7
`define DIST_0 30
`define DIST_1 55
`define DIST_2 78
`define DIST_3 94
`define DIST_4 110
`define DIST_5 124
`define DIST_6 136

`endif

// File: rtl/maze_pkg.sv
// Shared types of the maze view generator
// Every RTL file refers to these by scoped name
`include "maze_defines.svh"

package maze_pkg;

    typedef enum logic [1:0] {
        dir_east  = 2'd0,
        dir_north = 2'd1,
        dir_west  = 2'd2,
        dir_south = 2'd3
    } dir_t;

    typedef logic signed [3:0]  cell_t;     // Map index, -1 up to 7
    typedef logic signed [15:0] coord_t;    // Screen coordinate

    typedef struct packed {
        coord_t x;
        coord_t y;
    } point_t;

    typedef struct packed {
        point_t v0;
        point_t v1;
        point_t v2;
        point_t v3;
    } quad_t;

    // Screen distance v(k) of depth k, v(0) is the screen edge
    function automatic coord_t persp(input logic [2:0] k);
        case (k)
            3'd1:    return coord_t'(`DIST_0);
            3'd2:    return coord_t'(`DIST_1);
            3'd3:    return coord_t'(`DIST_2);
            3'd4:    return coord_t'(`DIST_3);
            3'd5:    return coord_t'(`DIST_4);
            3'd6:    return coord_t'(`DIST_5);
            3'd7:    return coord_t'(`DIST_6);
            default: return '0;
        endcase
    endfunction

endpackage

// File: rtl/maze_ifs.sv
// Interfaces between the probe, the side scanners and the quad emitter
`timescale 1ns/1ps

// Scan command from the probe, plus a combinational map read port
interface scan_cmd_if;
    logic            start;         // One cycle pulse per refresh
    maze_pkg::cell_t org_x;         // Player cell
    maze_pkg::cell_t org_y;
    maze_pkg::cell_t fwd_x;         // One step ahead
    maze_pkg::cell_t fwd_y;
    maze_pkg::cell_t side_x;        // One step towards this side
    maze_pkg::cell_t side_y;
    logic [2:0]      end_depth;     // Free cells ahead
    maze_pkg::cell_t rd_x;
    maze_pkg::cell_t rd_y;
    logic            rd_cell;       // 1 is wall

    modport command (
        output start, org_x, org_y, fwd_x, fwd_y, side_x, side_y, end_depth, rd_cell,
        input  rd_x, rd_y
    );

    modport scanner (
        input  start, org_x, org_y, fwd_x, fwd_y, side_x, side_y, end_depth, rd_cell,
        output rd_x, rd_y
    );
endinterface

// Quad stream, valid/ready with last, done flags a side with no runs
interface quad_stream_if;
    logic            valid;
    logic            ready;
    maze_pkg::quad_t quad;
    logic            last;
    logic            done;

    modport source (output valid, quad, last, done, input ready);
    modport sink   (input valid, quad, last, done, output ready);
endinterface

// File: rtl/corridor_probe.sv
// Corridor probe, holds the wall map and serves the map reads of both scanners
// On refresh it measures the free depth ahead and starts both side scans
`timescale 1ns/1ps
`include "maze_defines.svh"

module corridor_probe (
    input  logic             clk,
    input  logic             rstn,
    input  logic             refresh,
    input  maze_pkg::cell_t  player_x,
    input  maze_pkg::cell_t  player_y,
    input  maze_pkg::dir_t   facing,
    input  logic             busy,
    scan_cmd_if.command      cmd [2]
);

    logic [0:`MAP_COLS-1] map_q [0:`MAP_ROWS-1];    // map_q[y][x]

    logic            walking_q;
    logic            start_q;
    logic [2:0]      depth_q;
    maze_pkg::cell_t org_x_q, org_y_q;
    maze_pkg::cell_t fwd_x_q, fwd_y_q;
    maze_pkg::cell_t walk_x_q, walk_y_q;    // Cell one past depth_q
    maze_pkg::cell_t fwd_x_d, fwd_y_d;
    logic            ahead_wall;

    // Anything off the map is wall
    function automatic logic wall_at(input maze_pkg::cell_t x, input maze_pkg::cell_t y);
        if (x < 0 || x >= `MAP_COLS || y < 0 || y >= `MAP_ROWS) begin
            return 1'b1;
        end
        return map_q[y[2:0]][x[1:0]];
    endfunction

    // Facing to forward step, north is towards row 0
    always_comb begin
        fwd_x_d = '0;
        fwd_y_d = '0;
        case (facing)
            maze_pkg::dir_east:  fwd_x_d = 4'sd1;
            maze_pkg::dir_north: fwd_y_d = -4'sd1;
            maze_pkg::dir_west:  fwd_x_d = -4'sd1;
            default:             fwd_y_d = 4'sd1;
        endcase
    end

    assign ahead_wall = wall_at(walk_x_q, walk_y_q);

    // ==============================
    // Depth walk
    // ==============================
    always_ff @(posedge clk) begin
        if (!rstn) begin
            map_q[0]  <= `MAP_ROW0;
            map_q[1]  <= `MAP_ROW1;
            map_q[2]  <= `MAP_ROW2;
            map_q[3]  <= `MAP_ROW3;
            map_q[4]  <= `MAP_ROW4;
            map_q[5]  <= `MAP_ROW5;
            map_q[6]  <= `MAP_ROW6;
            walking_q <= 1'b0;
            start_q   <= 1'b0;
        end else begin
            start_q <= 1'b0;
            if (!walking_q && !busy && refresh) begin
                walking_q <= 1'b1;
                depth_q   <= '0;
                org_x_q   <= player_x;
                org_y_q   <= player_y;
                fwd_x_q   <= fwd_x_d;
                fwd_y_q   <= fwd_y_d;
                walk_x_q  <= player_x + fwd_x_d;
                walk_y_q  <= player_y + fwd_y_d;
            end else if (walking_q) begin
                if (ahead_wall || depth_q == 3'(`MAX_DEPTH - 1)) begin
                    walking_q <= 1'b0;
                    start_q   <= 1'b1;      // Depth settled, launch the scanners
                end else begin
                    depth_q  <= depth_q + 3'd1;
                    walk_x_q <= walk_x_q + fwd_x_q;
                    walk_y_q <= walk_y_q + fwd_y_q;
                end
            end
        end
    end

    // Left is forward turned a quarter to the left, right is its negation
    for (genvar i = 0; i < 2; i++) begin : g_cmd
        assign cmd[i].start     = start_q;
        assign cmd[i].org_x     = org_x_q;
        assign cmd[i].org_y     = org_y_q;
        assign cmd[i].fwd_x     = fwd_x_q;
        assign cmd[i].fwd_y     = fwd_y_q;
        assign cmd[i].side_x    = (i == 0) ? fwd_y_q : -fwd_y_q;
        assign cmd[i].side_y    = (i == 0) ? -fwd_x_q : fwd_x_q;
        assign cmd[i].end_depth = depth_q;
        assign cmd[i].rd_cell   = wall_at(cmd[i].rd_x, cmd[i].rd_y);
    end

endmodule

// File: rtl/wall_scanner.sv
// Side wall scanner, walks one side of the corridor a cell per cycle
// Each run of equal cells becomes one quad, MIRROR selects the right side
`timescale 1ns/1ps
`include "maze_defines.svh"

module wall_scanner #(
    parameter int MIRROR = 0        // 1 reflects every x about the screen
) (
    input  logic          clk,
    input  logic          rstn,
    scan_cmd_if.scanner   cmd,
    quad_stream_if.source out
);

    localparam maze_pkg::coord_t scr_w = `SCREEN_W;
    localparam maze_pkg::coord_t scr_h = `SCREEN_H;

    logic            scanning_q;
    logic [2:0]      k_q;           // Depth of the cell under test
    logic [2:0]      run_a_q;       // First depth of the open run
    logic            run_wall_q;
    maze_pkg::cell_t cur_x_q, cur_y_q;
    logic            valid_q;
    logic            last_q;
    logic            done_q;
    maze_pkg::quad_t quad_q;
    logic            advance;
    logic            at_end;
    logic            type_change;

    // Quad of the run from depth a up to b
    function automatic maze_pkg::quad_t make_quad(input logic [2:0] a, input logic [2:0] b,
                                                  input logic wall);
        maze_pkg::coord_t va;
        maze_pkg::coord_t vb;
        maze_pkg::quad_t  q;
        va     = maze_pkg::persp(a);
        vb     = maze_pkg::persp(b);
        q.v0.x = va;
        q.v0.y = wall ? va : vb;            // Open side shows the far wall only
        q.v1.x = vb;
        q.v1.y = vb;
        q.v2.x = vb;
        q.v2.y = scr_h - vb;
        q.v3.x = va;
        q.v3.y = wall ? scr_h - va : scr_h - vb;
        if (MIRROR != 0) begin
            q.v0.x = scr_w - q.v0.x;
            q.v1.x = scr_w - q.v1.x;
            q.v2.x = scr_w - q.v2.x;
            q.v3.x = scr_w - q.v3.x;
        end
        return q;
    endfunction

    assign cmd.rd_x = cur_x_q;
    assign cmd.rd_y = cur_y_q;

    assign advance     = !valid_q || out.ready;     // Output slot free this edge
    assign at_end      = (k_q == cmd.end_depth);
    assign type_change = (k_q != '0) && (cmd.rd_cell != run_wall_q);

    // ==============================
    // Run tracking
    // ==============================
    always_ff @(posedge clk) begin
        if (!rstn) begin
            scanning_q <= 1'b0;
            valid_q    <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (valid_q && out.ready) begin
                valid_q <= 1'b0;
            end
            if (cmd.start) begin
                scanning_q <= 1'b1;
                k_q        <= '0;
                cur_x_q    <= cmd.org_x + cmd.side_x;
                cur_y_q    <= cmd.org_y + cmd.side_y;
            end else if (scanning_q && advance) begin
                if (at_end) begin
                    // Depth e only closes the open run
                    scanning_q <= 1'b0;
                    done_q     <= (k_q == '0);
                    if (k_q != '0) begin
                        valid_q <= 1'b1;
                        last_q  <= 1'b1;
                        quad_q  <= make_quad(run_a_q, k_q, run_wall_q);
                    end
                end else begin
                    if (type_change) begin
                        valid_q <= 1'b1;
                        last_q  <= 1'b0;
                        quad_q  <= make_quad(run_a_q, k_q, run_wall_q);
                    end
                    if (k_q == '0 || type_change) begin
                        run_a_q <= k_q;             // New run opens here
                    end
                    run_wall_q <= cmd.rd_cell;
                    k_q        <= k_q + 3'd1;
                    cur_x_q    <= cur_x_q + cmd.fwd_x;
                    cur_y_q    <= cur_y_q + cmd.fwd_y;
                end
            end
        end
    end

    assign out.valid = valid_q;
    assign out.quad  = quad_q;
    assign out.last  = last_q;
    assign out.done  = done_q;

    // Scan stays within the probe's depth, which stays inside the table
    a_depth_bound: assert property (@(posedge clk) disable iff (!rstn)
        scanning_q |-> (k_q <= cmd.end_depth) && (cmd.end_depth <= 3'(`MAX_DEPTH - 1)));

endmodule

// File: rtl/quad_emitter.sv
// Quad emitter, drains the left then the right scanner, then adds the frame
// and end quads, offsets every vertex and registers the output stream
`timescale 1ns/1ps
`include "maze_defines.svh"

module quad_emitter (
    input  logic             clk,
    input  logic             rstn,
    input  logic             refresh,
    quad_stream_if.sink      side [2],
    input  logic [2:0]       end_depth,
    output logic             quad_valid,
    input  logic             quad_ready,
    output maze_pkg::coord_t q_x0, q_y0,
    output maze_pkg::coord_t q_x1, q_y1,
    output maze_pkg::coord_t q_x2, q_y2,
    output maze_pkg::coord_t q_x3, q_y3,
    output logic             busy,
    output logic             done
);

    localparam maze_pkg::coord_t scr_w = `SCREEN_W;
    localparam maze_pkg::coord_t scr_h = `SCREEN_H;
    localparam maze_pkg::coord_t offs  = `VIEW_DISPLACE;

    typedef enum logic [2:0] {
        st_idle, st_left, st_right, st_frame, st_end, st_drain, st_fin
    } state_t;

    state_t           state_q;
    logic             valid_q;
    logic             done_q;
    logic [1:0]       empty_q;      // Sticky side-empty flags
    maze_pkg::quad_t  quad_q;
    maze_pkg::quad_t  frame_quad;
    maze_pkg::quad_t  end_quad;
    maze_pkg::coord_t end_v;
    logic             slot_free;

    function automatic maze_pkg::quad_t shift(input maze_pkg::quad_t q);
        maze_pkg::quad_t r;
        r.v0.x = q.v0.x + offs;
        r.v0.y = q.v0.y + offs;
        r.v1.x = q.v1.x + offs;
        r.v1.y = q.v1.y + offs;
        r.v2.x = q.v2.x + offs;
        r.v2.y = q.v2.y + offs;
        r.v3.x = q.v3.x + offs;
        r.v3.y = q.v3.y + offs;
        return r;
    endfunction

    assign end_v = maze_pkg::persp(end_depth);

    always_comb begin
        frame_quad.v0 = '{'0, '0};
        frame_quad.v1 = '{scr_w, '0};
        frame_quad.v2 = '{scr_w, scr_h};
        frame_quad.v3 = '{'0, scr_h};
        end_quad.v0   = '{end_v, end_v};            // Far wall of the corridor
        end_quad.v1   = '{scr_w - end_v, end_v};
        end_quad.v2   = '{scr_w - end_v, scr_h - end_v};
        end_quad.v3   = '{end_v, scr_h - end_v};
    end

    assign slot_free     = !valid_q || quad_ready;
    assign side[0].ready = (state_q == st_left) && slot_free;
    assign side[1].ready = (state_q == st_right) && slot_free;

    // ==============================
    // Sequencing
    // ==============================
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= st_idle;
            valid_q <= 1'b0;
            done_q  <= 1'b0;
            empty_q <= '0;
        end else begin
            done_q  <= 1'b0;
            empty_q <= empty_q | {side[1].done, side[0].done};
            if (valid_q && quad_ready) begin
                valid_q <= 1'b0;
            end
            case (state_q)
                st_idle: begin
                    if (refresh) begin
                        empty_q <= '0;
                        state_q <= st_left;
                    end
                end
                st_left: begin
                    if (side[0].valid && side[0].ready) begin
                        valid_q <= 1'b1;
                        quad_q  <= shift(side[0].quad);
                        if (side[0].last) begin
                            state_q <= st_right;
                        end
                    end else if (empty_q[0] || side[0].done) begin
                        state_q <= st_right;
                    end
                end
                st_right: begin
                    if (side[1].valid && side[1].ready) begin
                        valid_q <= 1'b1;
                        quad_q  <= shift(side[1].quad);
                        if (side[1].last) begin
                            state_q <= st_frame;
                        end
                    end else if (empty_q[1] || side[1].done) begin
                        state_q <= st_frame;
                    end
                end
                st_frame: begin
                    if (slot_free) begin
                        valid_q <= 1'b1;
                        quad_q  <= shift(frame_quad);
                        state_q <= st_end;
                    end
                end
                st_end: begin
                    if (slot_free) begin
                        valid_q <= 1'b1;
                        quad_q  <= shift(end_quad);
                        state_q <= st_drain;
                    end
                end
                st_drain: begin
                    if (valid_q && quad_ready) begin
                        state_q <= st_fin;      // End quad accepted
                    end
                end
                default: begin
                    done_q  <= 1'b1;
                    state_q <= st_idle;
                end
            endcase
        end
    end

    assign busy       = (state_q != st_idle);
    assign done       = done_q;
    assign quad_valid = valid_q;
    assign q_x0       = quad_q.v0.x;
    assign q_y0       = quad_q.v0.y;
    assign q_x1       = quad_q.v1.x;
    assign q_y1       = quad_q.v1.y;
    assign q_x2       = quad_q.v2.x;
    assign q_y2       = quad_q.v2.y;
    assign q_x3       = quad_q.v3.x;
    assign q_y3       = quad_q.v3.y;

    // A stalled output keeps its quad until accepted
    a_hold: assert property (@(posedge clk) disable iff (!rstn)
        quad_valid && !quad_ready |=> quad_valid && $stable(quad_q));

endmodule

// File: rtl/maze_view_top.sv
// Maze view generator top level
// Takes a refresh with player cell and facing, streams the corridor quads out
`timescale 1ns/1ps

module maze_view_top (
    input  logic             clk,
    input  logic             rstn,
    input  logic             refresh,
    input  maze_pkg::cell_t  player_x,
    input  maze_pkg::cell_t  player_y,
    input  maze_pkg::dir_t   facing,
    input  logic             quad_ready,
    output logic             quad_valid,
    output maze_pkg::coord_t q_x0, q_y0,
    output maze_pkg::coord_t q_x1, q_y1,
    output maze_pkg::coord_t q_x2, q_y2,
    output maze_pkg::coord_t q_x3, q_y3,
    output logic             busy,
    output logic             done
);

    scan_cmd_if    cmd_bus  [2] ();     // Index 0 left, 1 right
    quad_stream_if quad_bus [2] ();

    corridor_probe u_probe (
        .clk      (clk),
        .rstn     (rstn),
        .refresh  (refresh),
        .player_x (player_x),
        .player_y (player_y),
        .facing   (facing),
        .busy     (busy),
        .cmd      (cmd_bus)
    );

    for (genvar i = 0; i < 2; i++) begin : g_side
        wall_scanner #(.MIRROR(i)) u_scanner (
            .clk  (clk),
            .rstn (rstn),
            .cmd  (cmd_bus[i]),
            .out  (quad_bus[i])
        );
    end

    quad_emitter u_emitter (
        .clk        (clk),
        .rstn       (rstn),
        .refresh    (refresh),
        .side       (quad_bus),
        .end_depth  (cmd_bus[0].end_depth),
        .quad_valid (quad_valid),
        .quad_ready (quad_ready),
        .q_x0       (q_x0),
        .q_y0       (q_y0),
        .q_x1       (q_x1),
        .q_y1       (q_y1),
        .q_x2       (q_x2),
        .q_y2       (q_y2),
        .q_x3       (q_x3),
        .q_y3       (q_y3),
        .busy       (busy),
        .done       (done)
    );

endmodule

// File: bench/maze_view_tb.sv
// Testbench for the maze view generator
// Replays the refresh records of the stim file and compares every streamed quad
`timescale 1ns/1ps
`include "maze_defines.svh"

module maze_view_tb;

    localparam int clk_half  = 4;                           // 8 ns period
    localparam int max_quads = 2 * (`MAX_DEPTH - 1) + 2;    // Both sides plus frame and end

    logic             clk;
    logic             rstn;
    logic             refresh;
    maze_pkg::cell_t  player_x;
    maze_pkg::cell_t  player_y;
    maze_pkg::dir_t   facing;
    logic             quad_ready;
    logic             quad_valid;
    maze_pkg::coord_t q_x0, q_y0, q_x1, q_y1, q_x2, q_y2, q_x3, q_y3;
    logic             busy;
    logic             done;

    logic [15:0]      stim_mem [0:511];
    int               num_records;
    logic             stim_loaded;
    integer           seed;
    int               ptr;          // Next record in stim_mem

    maze_view_top dut (
        .clk        (clk),
        .rstn       (rstn),
        .refresh    (refresh),
        .player_x   (player_x),
        .player_y   (player_y),
        .facing     (facing),
        .quad_ready (quad_ready),
        .quad_valid (quad_valid),
        .q_x0       (q_x0),
        .q_y0       (q_y0),
        .q_x1       (q_x1),
        .q_y1       (q_y1),
        .q_x2       (q_x2),
        .q_y2       (q_y2),
        .q_x3       (q_x3),
        .q_y3       (q_y3),
        .busy       (busy),
        .done       (done)
    );

    initial begin
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    // ==============================
    // Checks
    // ==============================
    task automatic report_failure(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped at %0t", $time);
    endtask

    task automatic check_quad(input string name, input maze_pkg::quad_t got,
                              input maze_pkg::quad_t exp);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
        end
    endtask

    function automatic maze_pkg::quad_t dut_quad();
        maze_pkg::quad_t q;
        q.v0 = '{q_x0, q_y0};
        q.v1 = '{q_x1, q_y1};
        q.v2 = '{q_x2, q_y2};
        q.v3 = '{q_x3, q_y3};
        return q;
    endfunction

    // Eight words per quad, x before y
    function automatic maze_pkg::quad_t stim_quad(input int base);
        maze_pkg::quad_t q;
        q.v0.x = maze_pkg::coord_t'(stim_mem[base]);
        q.v0.y = maze_pkg::coord_t'(stim_mem[base + 1]);
        q.v1.x = maze_pkg::coord_t'(stim_mem[base + 2]);
        q.v1.y = maze_pkg::coord_t'(stim_mem[base + 3]);
        q.v2.x = maze_pkg::coord_t'(stim_mem[base + 4]);
        q.v2.y = maze_pkg::coord_t'(stim_mem[base + 5]);
        q.v3.x = maze_pkg::coord_t'(stim_mem[base + 6]);
        q.v3.y = maze_pkg::coord_t'(stim_mem[base + 7]);
        return q;
    endfunction

    // ==============================
    // One refresh record
    // ==============================
    task automatic run_record(input int r);
        maze_pkg::dir_t  face;
        maze_pkg::quad_t held_quad;
        logic            stall;
        logic            held;
        logic [31:0]     rnd;
        int              n;
        int              qbase;
        int              count;
        int              cycles;
        player_x = maze_pkg::cell_t'(stim_mem[ptr][3:0]);
        player_y = maze_pkg::cell_t'(stim_mem[ptr + 1][3:0]);
        face     = maze_pkg::dir_t'(stim_mem[ptr + 2][1:0]);
        stall    = stim_mem[ptr + 3][0];
        n        = int'(stim_mem[ptr + 4]);
        qbase    = ptr + 5;
        ptr      = qbase + 8 * n;
        count    = 0;
        cycles   = 0;
        held     = 1'b0;
        if (n < 2 || n > max_quads) begin
            report_failure($sformatf("record %0d of the stim file has a bad quad count", r));
        end
        check_flag("busy before refresh", busy, 1'b0);
        facing     = face;
        refresh    = 1'b1;
        quad_ready = 1'b1;
        @(negedge clk);
        refresh = 1'b0;
        check_flag("busy after refresh", busy, 1'b1);
        while (!done) begin
            if (!busy) begin
                report_failure($sformatf("busy fell without done in record %0d", r));
            end
            if (held) begin
                check_flag("quad_valid under stall", quad_valid, 1'b1);
                check_quad("quad under stall", dut_quad(), held_quad);
            end
            refresh = (cycles == 2);    // Second refresh lands while busy
            if (cycles == 2) begin
                facing = maze_pkg::dir_t'(face ^ 2'd1);
            end
            if (stall) begin
                rnd        = $random(seed);
                quad_ready = rnd[0];
            end else begin
                quad_ready = 1'b1;
            end
            if (quad_valid && quad_ready) begin
                if (count >= n) begin
                    report_failure($sformatf("record %0d sent more quads than expected", r));
                end
                check_quad($sformatf("record %0d quad %0d", r, count), dut_quad(),
                           stim_quad(qbase + 8 * count));
                count++;
            end
            held      = quad_valid && !quad_ready;
            held_quad = dut_quad();
            cycles++;
            @(negedge clk);
        end
        refresh = 1'b0;
        check_flag("busy with done", busy, 1'b0);
        check_count($sformatf("record %0d quad count", r), count, n);
        @(negedge clk);
        check_flag("done after its pulse", done, 1'b0);
        check_flag("busy after done", busy, 1'b0);
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        rstn        = 1'b0;
        refresh     = 1'b0;
        player_x    = '0;
        player_y    = '0;
        facing      = maze_pkg::dir_east;
        quad_ready  = 1'b0;
        seed        = 51;
        ptr         = 1;
        stim_loaded = 1'b0;
        $readmemh("bench/maze_view_stim.txt", stim_mem);
        num_records = $isunknown(stim_mem[0]) ? 0 : int'(stim_mem[0]);
        stim_loaded = 1'b1;
        if (num_records == 0) begin
            report_failure("stim file is missing or holds no records");
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        check_flag("busy after reset", busy, 1'b0);
        check_flag("done after reset", done, 1'b0);
        check_flag("quad_valid after reset", quad_valid, 1'b0);
        for (int r = 0; r < num_records; r++) begin
            run_record(r);
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

    // Watchdog, generous per record
    initial begin
        wait (stim_loaded);
        repeat (num_records * 200 + 100) @(posedge clk);
        report_failure("timeout, the testbench did not finish in time");
    end

endmodule

// File: maze_view.f
+incdir+include
rtl/maze_pkg.sv
rtl/maze_ifs.sv
rtl/corridor_probe.sv
rtl/wall_scanner.sv
rtl/quad_emitter.sv
rtl/maze_view_top.sv
bench/maze_view_tb.sv

// File: run.sh
#!/bin/sh
# Build the maze view testbench with Verilator, then run it.
# The exit status is nonzero when the build fails or the testbench stops with $fatal.
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module maze_view_tb \
    -f maze_view.f -o maze_view_sim &&
./obj_dir/maze_view_sim ||
{ echo "maze view simulation failed"; exit 1; }

// File: bench/maze_view_stim.txt
// Record count, then per record: player_x player_y facing stall quad_count
// followed by one quad per line: x0 y0 x1 y1 x2 y2 x3 y3 (displaced screen coords)
6
1 6 1 0 8
14 14 32 32 32 186 14 1a4
32 4b 4b 4b 4b 16d 32 16d
4b 4b 62 62 62 156 4b 16d
62 72 72 72 72 146 62 146
72 72 82 82 82 136 72 146
1a4 14 136 82 136 136 1a4 1a4
14 14 1a4 14 1a4 1a4 14 1a4
82 82 136 82 136 136 82 136
1 6 1 1 8
14 14 32 32 32 186 14 1a4
32 4b 4b 4b 4b 16d 32 16d
4b 4b 62 62 62 156 4b 16d
62 72 72 72 72 146 62 146
72 72 82 82 82 136 72 146
1a4 14 136 82 136 136 1a4 1a4
14 14 1a4 14 1a4 1a4 14 1a4
82 82 136 82 136 136 82 136
1 3 1 0 5
14 32 32 32 32 186 14 186
32 32 4b 4b 4b 16d 32 186
1a4 14 16d 4b 16d 16d 1a4 1a4
14 14 1a4 14 1a4 1a4 14 1a4
4b 4b 16d 4b 16d 16d 4b 16d
1 3 3 1 6
14 14 62 62 62 156 14 1a4
1a4 32 186 32 186 186 1a4 186
186 32 16d 4b 16d 16d 186 186
16d 62 156 62 156 156 16d 156
14 14 1a4 14 1a4 1a4 14 1a4
62 62 156 62 156 156 62 156
1 3 0 0 2
14 14 1a4 14 1a4 1a4 14 1a4
14 14 1a4 14 1a4 1a4 14 1a4
1 3 2 0 4
14 32 32 32 32 186 14 186
1a4 32 186 32 186 186 1a4 186
14 14 1a4 14 1a4 1a4 14 1a4
32 32 186 32 186 186 32 186
